//--- verilog/mrd_pkg.sv
package mrd_pkg;

	// bank and lane geometry
	localparam int N_BANKS    = 7;
	localparam int N_LANES    = 5;
	localparam int MAX_STAGES = 4;

	// data widths
	localparam int W_SAMPLE = 18;
	localparam int W_IDX    = 12;

	// marks a lane with no bank behind it
	localparam logic [2:0] BANK_NONE = 3'd7;

	// ------------------------------------------------------------------
	// sequencer states
	// ------------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE,
		SINK,
		RD,
		WAIT_WR_END
	} mrd_state_e;

endpackage

//--- verilog/mrd_div7.sv
`timescale 1ns/1ps

module mrd_div7
	import mrd_pkg::*;
(
	input  logic [W_IDX-1:0] idx,
	output logic [W_IDX-1:0] row,
	output logic [2:0]       bank
);

logic [3:0] rem;

// restoring division, one quotient bit per level
always_comb
begin
	rem = '0;
	for (int i = W_IDX - 1; i >= 0; i--)
	begin
		rem = {rem[2:0], idx[i]};
		if (rem >= 4'd7)
		begin
			rem    = rem - 4'd7;
			row[i] = 1'b1;
		end
		else
			row[i] = 1'b0;
	end
	bank = rem[2:0];
end

endmodule

//--- verilog/mrd_bank_ram.sv
`timescale 1ns/1ps

module mrd_bank_ram
	import mrd_pkg::*;
#(
	parameter int BANK_AW = 5
)
(
	input  logic                                clk,
	input  logic [0:N_BANKS-1]                  we,
	input  logic [BANK_AW-1:0]                  wraddr,
	input  logic [W_SAMPLE-1:0]                 wr_real,
	input  logic [W_SAMPLE-1:0]                 wr_imag,
	input  logic [0:N_BANKS-1]                  rden,
	input  logic [0:N_BANKS-1][BANK_AW-1:0]     rdaddr,
	output logic [0:N_BANKS-1][W_SAMPLE-1:0]    dout_real,
	output logic [0:N_BANKS-1][W_SAMPLE-1:0]    dout_imag
);

for (genvar b = 0; b < N_BANKS; b++)
begin : g_bank
	// real part in the upper half of each word
	logic [2*W_SAMPLE-1:0] mem [2**BANK_AW];
	logic [2*W_SAMPLE-1:0] rd_q;

	always_ff @(posedge clk)
	begin
		if (we[b])
			mem[wraddr] <= {wr_real, wr_imag};
		if (rden[b])
			rd_q <= mem[rdaddr[b]];
	end

	assign dout_real[b] = rd_q[2*W_SAMPLE-1:W_SAMPLE];
	assign dout_imag[b] = rd_q[W_SAMPLE-1:0];

	// sink and read phases never overlap on a bank
	assert property (@(posedge clk) (we[b] && rden[b]) !== 1'b1);
end

endmodule

//--- verilog/mrd_seq_fsm.sv
`timescale 1ns/1ps

module mrd_seq_fsm
	import mrd_pkg::*;
#(
	parameter int WAIT_CYCLES = 4
)
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  logic [2:0]       num_stages,
	input  logic             in_valid,
	input  logic             grp_last,
	input  logic             rd_end,
	input  logic [W_IDX-1:0] n_points,
	output mrd_state_e       state,
	output logic [W_IDX-1:0] sink_idx,
	output logic             sink_we,
	output logic             stage_start,
	output logic [2:0]       cnt_stage,
	output logic             done
);

localparam int W_GAP = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

logic [2:0]       stages_r;
logic [W_GAP-1:0] gap_cnt;
logic             last_stage;
logic             gap_done;

assign sink_we    = (state == SINK) && in_valid;
assign last_stage = (cnt_stage == stages_r - 3'd1);
assign gap_done   = (int'(gap_cnt) >= WAIT_CYCLES - 1);
assign done       = (state == WAIT_WR_END) && last_stage && rd_end;

// stage count is held for the whole transform
always_ff @(posedge clk)
begin
	if (state == IDLE && start)
		stages_r <= num_stages;
end

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		state       <= IDLE;
		sink_idx    <= '0;
		stage_start <= 1'b0;
		cnt_stage   <= '0;
		gap_cnt     <= '0;
	end
	else
	begin
		stage_start <= 1'b0;
		case (state)
			IDLE:
			begin
				sink_idx  <= '0;
				cnt_stage <= '0;
				if (start)
					state <= SINK;
			end
			SINK:
			begin
				if (sink_we)
				begin
					sink_idx <= sink_idx + 1'b1;
					// last point written, first stage may start
					if (sink_idx == n_points - 1'b1)
					begin
						state       <= RD;
						stage_start <= 1'b1;
					end
				end
			end
			RD:
			begin
				gap_cnt <= '0;
				if (grp_last)
					state <= WAIT_WR_END;
			end
			WAIT_WR_END:
			begin
				if (last_stage)
				begin
					if (rd_end)
						state <= IDLE;
				end
				else if (gap_done)
				begin
					state       <= RD;
					stage_start <= 1'b1;
					cnt_stage   <= cnt_stage + 3'd1;
				end
				else
					gap_cnt <= gap_cnt + 1'b1;
			end
			default:
				state <= IDLE;
		endcase
	end
end

assert property (@(posedge clk) disable iff (!rst_n)
	(start && state == IDLE) |-> (num_stages >= 3'd2 && num_stages <= 3'(MAX_STAGES)));

endmodule

//--- verilog/mrd_cta_addr.sv
`timescale 1ns/1ps

module mrd_cta_addr
	import mrd_pkg::*;
(
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               start,
	input  logic [2:0]                         num_stages,
	input  logic [0:MAX_STAGES-1][2:0]         factor,
	input  logic                               stage_start,
	input  logic [2:0]                         cnt_stage,
	output logic [W_IDX-1:0]                   n_points,
	output logic                               grp_valid,
	output logic                               grp_last,
	output logic [0:N_LANES-1][W_IDX-1:0]      pt_idx,
	output logic [0:N_LANES-1][W_IDX-1:0]      twdl_numrtr,
	output logic [W_IDX-1:0]                   twdl_demontr,
	output logic [2:0]                         grp_factor
);

logic [W_IDX-1:0] len_c;
logic [W_IDX-1:0] span_c;
logic [W_IDX-1:0] stride_c;
logic [W_IDX-1:0] stride;
logic [W_IDX-1:0] base;
logic [W_IDX-1:0] offset;
logic [W_IDX-1:0] pt_c;
logic [W_IDX-1:0] tw_c;

// ----------------------------------------------------------------------
// length, span and stride as running products
// ----------------------------------------------------------------------
always_comb
begin
	len_c    = W_IDX'(1);
	span_c   = W_IDX'(1);
	stride_c = W_IDX'(1);
	for (int i = 0; i < MAX_STAGES; i++)
	begin
		if (i < int'(num_stages))
		begin
			len_c = W_IDX'(len_c * factor[i]);
			if (i >= int'(cnt_stage))
				span_c = W_IDX'(span_c * factor[i]);
			if (i > int'(cnt_stage))
				stride_c = W_IDX'(stride_c * factor[i]);
		end
	end
end

always_ff @(posedge clk)
begin
	if (start)
		n_points <= len_c;
	if (stage_start)
	begin
		twdl_demontr <= span_c;
		stride       <= stride_c;
		grp_factor   <= factor[cnt_stage];
	end
end

// ----------------------------------------------------------------------
// block base and offset counters, one group per cycle
// ----------------------------------------------------------------------
assign grp_last = grp_valid && (offset == stride - 1'b1) && (base + twdl_demontr == n_points);

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		grp_valid <= 1'b0;
		base      <= '0;
		offset    <= '0;
	end
	else if (stage_start)
	begin
		grp_valid <= 1'b1;
		base      <= '0;
		offset    <= '0;
	end
	else if (grp_valid)
	begin
		if (grp_last)
			grp_valid <= 1'b0;
		if (offset == stride - 1'b1)
		begin
			offset <= '0;
			base   <= base + twdl_demontr;
		end
		else
			offset <= offset + 1'b1;
	end
end

// lane k sits k strides on, twiddle k*j by repeated add
always_comb
begin
	pt_c = base + offset;
	tw_c = '0;
	for (int k = 0; k < N_LANES; k++)
	begin
		if (k < int'(grp_factor))
		begin
			pt_idx[k]      = pt_c;
			twdl_numrtr[k] = tw_c;
		end
		else
		begin
			pt_idx[k]      = '0;
			twdl_numrtr[k] = '0;
		end
		pt_c = pt_c + stride;
		tw_c = tw_c + offset;
	end
end

for (genvar i = 0; i < MAX_STAGES; i++)
begin : g_fac_chk
	assert property (@(posedge clk) disable iff (!rst_n)
		(start && i < num_stages) |-> (factor[i] >= 3'd2 && factor[i] <= 3'd5));
end

endmodule

//--- verilog/mrd_rd_sched.sv
`timescale 1ns/1ps

module mrd_rd_sched
	import mrd_pkg::*;
#(
	parameter int BANK_AW = 5
)
(
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               grp_valid,
	input  logic [0:N_LANES-1][W_IDX-1:0]      pt_idx,
	input  logic [0:N_LANES-1][W_IDX-1:0]      twdl_numrtr,
	input  logic [W_IDX-1:0]                   twdl_demontr,
	input  logic [2:0]                         grp_factor,
	input  logic [2:0]                         cnt_stage,
	input  logic                               grp_last,
	input  logic [0:N_BANKS-1][W_SAMPLE-1:0]   dout_real,
	input  logic [0:N_BANKS-1][W_SAMPLE-1:0]   dout_imag,
	output logic [0:N_BANKS-1]                 rden,
	output logic [0:N_BANKS-1][BANK_AW-1:0]    rdaddr,
	output logic                               rd_end,
	output logic                               out_valid,
	output logic [0:N_LANES-1][W_SAMPLE-1:0]   out_real,
	output logic [0:N_LANES-1][W_SAMPLE-1:0]   out_imag,
	output logic [0:N_LANES-1][W_IDX-1:0]      out_twdl_numrtr,
	output logic [W_IDX-1:0]                   out_twdl_demontr,
	output logic [2:0]                         out_factor,
	output logic [2:0]                         out_stage,
	output logic                               stage_end
);

localparam int W_SIDE = N_LANES * W_IDX + W_IDX + 6;

logic [0:N_LANES-1][W_IDX-1:0]   lane_row;
logic [0:N_LANES-1][2:0]         lane_bank;
logic [0:N_LANES-1][BANK_AW-1:0] row1;
logic [0:N_LANES-1][2:0]         idx1;
logic [0:N_LANES-1][2:0]         idx2;
logic [0:N_LANES-1][2:0]         idx3;
logic [0:N_BANKS-1]              bank_hit;
logic [0:N_BANKS-1][BANK_AW-1:0] bank_row;
logic [2:0]                      vld_d;
logic [2:0]                      last_d;
logic [0:2][W_SIDE-1:0]          side_d;
logic                            bank_clash;

// ----------------------------------------------------------------------
// stage 1: point index to row and bank
// ----------------------------------------------------------------------
for (genvar k = 0; k < N_LANES; k++)
begin : g_lane
	mrd_div7 i_div7 (
		.idx  (pt_idx[k]),
		.row  (lane_row[k]),
		.bank (lane_bank[k])
	);
end

always_ff @(posedge clk)
begin
	for (int k = 0; k < N_LANES; k++)
		row1[k] <= lane_row[k][BANK_AW-1:0];
end

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		idx1   <= {N_LANES{BANK_NONE}};
		idx2   <= {N_LANES{BANK_NONE}};
		idx3   <= {N_LANES{BANK_NONE}};
		vld_d  <= '0;
		last_d <= '0;
		rden   <= '0;
	end
	else
	begin
		// lanes past the factor, and idle cycles, read nothing
		for (int k = 0; k < N_LANES; k++)
			idx1[k] <= (grp_valid && 3'(k) < grp_factor) ? lane_bank[k] : BANK_NONE;
		idx2   <= idx1;
		idx3   <= idx2;
		vld_d  <= {vld_d[1:0], grp_valid};
		last_d <= {last_d[1:0], grp_valid && grp_last};
		rden   <= bank_hit;
	end
end

// ----------------------------------------------------------------------
// stage 2: per-bank enable and row, lowest lane wins
// ----------------------------------------------------------------------
always_comb
begin
	for (int b = 0; b < N_BANKS; b++)
	begin
		bank_hit[b] = 1'b0;
		bank_row[b] = '0;
		for (int k = N_LANES - 1; k >= 0; k--)
		begin
			if (idx1[k] == 3'(b))
			begin
				bank_hit[b] = 1'b1;
				bank_row[b] = row1[k];
			end
		end
	end
end

always_ff @(posedge clk)
begin
	rdaddr <= bank_row;
end

// side data rides alongside the reads
always_ff @(posedge clk)
begin
	side_d[0] <= {twdl_numrtr, twdl_demontr, grp_factor, cnt_stage};
	side_d[1] <= side_d[0];
	side_d[2] <= side_d[1];
end

// ----------------------------------------------------------------------
// stage 3: steer bank outputs back onto lanes
// ----------------------------------------------------------------------
always_comb
begin
	for (int k = 0; k < N_LANES; k++)
	begin
		if (idx3[k] == BANK_NONE)
		begin
			out_real[k] = '0;
			out_imag[k] = '0;
		end
		else
		begin
			out_real[k] = dout_real[idx3[k]];
			out_imag[k] = dout_imag[idx3[k]];
		end
	end
end

assign {out_twdl_numrtr, out_twdl_demontr, out_factor, out_stage} = side_d[2];
assign out_valid = vld_d[2];
assign rd_end    = vld_d[2] && last_d[2];
assign stage_end = rd_end;

// the bank map must keep every group conflict-free
always_comb
begin
	bank_clash = 1'b0;
	for (int i = 0; i < N_LANES; i++)
		for (int j = i + 1; j < N_LANES; j++)
			if (idx1[i] != BANK_NONE && idx1[i] == idx1[j])
				bank_clash = 1'b1;
end

assert property (@(posedge clk) disable iff (!rst_n) !bank_clash);

endmodule

//--- verilog/mrd_top.sv
`timescale 1ns/1ps

module mrd_top
	import mrd_pkg::*;
#(
	parameter int BANK_AW     = 5,
	parameter int WAIT_CYCLES = 4
)
(
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               start,
	input  logic [2:0]                         num_stages,
	input  logic [0:MAX_STAGES-1][2:0]         factor,
	input  logic                               in_valid,
	input  logic [W_SAMPLE-1:0]                in_real,
	input  logic [W_SAMPLE-1:0]                in_imag,
	output logic                               out_valid,
	output logic [0:N_LANES-1][W_SAMPLE-1:0]   out_real,
	output logic [0:N_LANES-1][W_SAMPLE-1:0]   out_imag,
	output logic [0:N_LANES-1][W_IDX-1:0]      out_twdl_numrtr,
	output logic [W_IDX-1:0]                   out_twdl_demontr,
	output logic [2:0]                         out_factor,
	output logic [2:0]                         out_stage,
	output logic                               stage_end,
	output logic                               done
);

mrd_state_e                      state;
logic [W_IDX-1:0]                sink_idx;
logic                            sink_we;
logic [W_IDX-1:0]                sink_row;
logic [2:0]                      sink_bank;
logic [0:N_BANKS-1]              bank_we;
logic                            stage_start;
logic [2:0]                      cnt_stage;
logic [W_IDX-1:0]                n_points;
logic                            rd_end;
logic                            grp_valid;
logic                            grp_last;
logic [0:N_LANES-1][W_IDX-1:0]   pt_idx;
logic [0:N_LANES-1][W_IDX-1:0]   twdl_numrtr;
logic [W_IDX-1:0]                twdl_demontr;
logic [2:0]                      grp_factor;
logic [0:N_BANKS-1]              rden;
logic [0:N_BANKS-1][BANK_AW-1:0] rdaddr;
logic [0:N_BANKS-1][W_SAMPLE-1:0] dout_real;
logic [0:N_BANKS-1][W_SAMPLE-1:0] dout_imag;

mrd_seq_fsm #(
	.WAIT_CYCLES (WAIT_CYCLES)
) i_seq_fsm (
	.clk         (clk),
	.rst_n       (rst_n),
	.start       (start),
	.num_stages  (num_stages),
	.in_valid    (in_valid),
	.grp_last    (grp_last),
	.rd_end      (rd_end),
	.n_points    (n_points),
	.state       (state),
	.sink_idx    (sink_idx),
	.sink_we     (sink_we),
	.stage_start (stage_start),
	.cnt_stage   (cnt_stage),
	.done        (done)
);

mrd_cta_addr i_cta_addr (
	.clk          (clk),
	.rst_n        (rst_n),
	.start        (start),
	.num_stages   (num_stages),
	.factor       (factor),
	.stage_start  (stage_start),
	.cnt_stage    (cnt_stage),
	.n_points     (n_points),
	.grp_valid    (grp_valid),
	.grp_last     (grp_last),
	.pt_idx       (pt_idx),
	.twdl_numrtr  (twdl_numrtr),
	.twdl_demontr (twdl_demontr),
	.grp_factor   (grp_factor)
);

// sink write path, point n to bank n mod 7
mrd_div7 i_sink_div7 (
	.idx  (sink_idx),
	.row  (sink_row),
	.bank (sink_bank)
);

for (genvar b = 0; b < N_BANKS; b++)
begin : g_we
	assign bank_we[b] = sink_we && (sink_bank == 3'(b));
end

mrd_rd_sched #(
	.BANK_AW (BANK_AW)
) i_rd_sched (
	.clk              (clk),
	.rst_n            (rst_n),
	.grp_valid        (grp_valid),
	.pt_idx           (pt_idx),
	.twdl_numrtr      (twdl_numrtr),
	.twdl_demontr     (twdl_demontr),
	.grp_factor       (grp_factor),
	.cnt_stage        (cnt_stage),
	.grp_last         (grp_last),
	.dout_real        (dout_real),
	.dout_imag        (dout_imag),
	.rden             (rden),
	.rdaddr           (rdaddr),
	.rd_end           (rd_end),
	.out_valid        (out_valid),
	.out_real         (out_real),
	.out_imag         (out_imag),
	.out_twdl_numrtr  (out_twdl_numrtr),
	.out_twdl_demontr (out_twdl_demontr),
	.out_factor       (out_factor),
	.out_stage        (out_stage),
	.stage_end        (stage_end)
);

mrd_bank_ram #(
	.BANK_AW (BANK_AW)
) i_bank_ram (
	.clk       (clk),
	.we        (bank_we),
	.wraddr    (sink_row[BANK_AW-1:0]),
	.wr_real   (in_real),
	.wr_imag   (in_imag),
	.rden      (rden),
	.rdaddr    (rdaddr),
	.dout_real (dout_real),
	.dout_imag (dout_imag)
);

// read results only ever leave while the sequencer is reading
assert property (@(posedge clk) disable iff (!rst_n)
	out_valid |-> (state == RD || state == WAIT_WR_END));

endmodule

//--- dv/tb_mrd_top.sv
`timescale 1ns/1ps

module tb_mrd_top
	import mrd_pkg::*;
();

localparam int BANK_AW     = 5;
localparam int WAIT_CYCLES = 4;
localparam int N_TESTS     = 6;
localparam int MAX_POINTS  = N_BANKS * (2 ** BANK_AW);

// ----------------------------------------------------------------------
// stimulus table: stage count, factors, expected length, max load gap
// ----------------------------------------------------------------------
int tbl_stages [N_TESTS] = '{3, 2, 4, 3, 2, 3};
int tbl_fac [N_TESTS][MAX_STAGES] = '{'{2, 3, 5, 0}, '{4, 5, 0, 0}, '{3, 3, 2, 2},
	'{5, 5, 5, 0}, '{2, 2, 0, 0}, '{2, 3, 5, 0}};
int tbl_points [N_TESTS] = '{30, 20, 36, 125, 4, 30};
// gap 0 loads back-to-back
int tbl_gap [N_TESTS] = '{2, 2, 2, 2, 0, 0};

logic                             clk;
logic                             rst_n;
logic                             start;
logic [2:0]                       num_stages;
logic [0:MAX_STAGES-1][2:0]       factor;
logic                             in_valid;
logic [W_SAMPLE-1:0]              in_real;
logic [W_SAMPLE-1:0]              in_imag;
logic                             out_valid;
logic [0:N_LANES-1][W_SAMPLE-1:0] out_real;
logic [0:N_LANES-1][W_SAMPLE-1:0] out_imag;
logic [0:N_LANES-1][W_IDX-1:0]    out_twdl_numrtr;
logic [W_IDX-1:0]                 out_twdl_demontr;
logic [2:0]                       out_factor;
logic [2:0]                       out_stage;
logic                             stage_end;
logic                             done;

logic [W_SAMPLE-1:0] model_re [MAX_POINTS];
logic [W_SAMPLE-1:0] model_im [MAX_POINTS];
int                  cycle_cnt = 0;
int                  cycle_limit;

mrd_top #(
	.BANK_AW     (BANK_AW),
	.WAIT_CYCLES (WAIT_CYCLES)
) i_dut (
	.clk              (clk),
	.rst_n            (rst_n),
	.start            (start),
	.num_stages       (num_stages),
	.factor           (factor),
	.in_valid         (in_valid),
	.in_real          (in_real),
	.in_imag          (in_imag),
	.out_valid        (out_valid),
	.out_real         (out_real),
	.out_imag         (out_imag),
	.out_twdl_numrtr  (out_twdl_numrtr),
	.out_twdl_demontr (out_twdl_demontr),
	.out_factor       (out_factor),
	.out_stage        (out_stage),
	.stage_end        (stage_end),
	.done             (done)
);

always #50 clk = ~clk;

always @(posedge clk)
begin
	cycle_cnt <= cycle_cnt + 1;
	if (cycle_cnt >= cycle_limit)
		report_error($sformatf("timeout after %0d cycles, the DUT stopped producing groups",
			cycle_cnt));
end

// ----------------------------------------------------------------------
// checks
// ----------------------------------------------------------------------
task automatic report_error(input string msg);
	$display("%s", msg);
	$display("Simulation failed");
	$fatal(1);
endtask

task automatic check_sample(input string name, input logic [W_SAMPLE-1:0] exp,
	input logic [W_SAMPLE-1:0] act);
	if (act !== exp)
		report_error($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, act));
endtask

task automatic check_idx(input string name, input logic [W_IDX-1:0] exp,
	input logic [W_IDX-1:0] act);
	if (act !== exp)
		report_error($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, act));
endtask

task automatic check_factor(input string name, input logic [2:0] exp, input logic [2:0] act);
	if (act !== exp)
		report_error($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp)
		report_error($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, exp, act));
endtask

// ----------------------------------------------------------------------
// stimulus and model
// ----------------------------------------------------------------------
task automatic start_transform(input int t);
	@(posedge clk);
	#1;
	start      = 1'b1;
	num_stages = 3'(tbl_stages[t]);
	for (int i = 0; i < MAX_STAGES; i++)
		factor[i] = 3'(tbl_fac[t][i]);
	@(posedge clk);
	#1;
	start = 1'b0;
endtask

task automatic load_samples(input int n, input int gap_max);
	int gap;
	for (int i = 0; i < n; i++)
	begin
		gap = (gap_max == 0) ? 0 : $urandom_range(gap_max, 0);
		repeat (gap)
		begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
			start    = 1'b0;
		end
		@(posedge clk);
		#1;
		model_re[i] = W_SAMPLE'($urandom());
		model_im[i] = W_SAMPLE'($urandom());
		in_valid    = 1'b1;
		in_real     = model_re[i];
		in_imag     = model_im[i];
		// stray start halfway through the load
		start = (i == n / 2);
	end
	@(posedge clk);
	#1;
	in_valid = 1'b0;
	start    = 1'b0;
endtask

task automatic collect_stage(input int t, input int s);
	int   fac;
	int   span;
	int   stride;
	int   n_grp;
	int   b;
	int   j;
	int   pt;
	logic last_stage;
	logic [W_SAMPLE-1:0] exp_re;
	logic [W_SAMPLE-1:0] exp_im;
	logic [W_IDX-1:0]    exp_tw;
	fac  = tbl_fac[t][s];
	span = 1;
	for (int i = s; i < tbl_stages[t]; i++)
		span = span * tbl_fac[t][i];
	stride     = span / fac;
	n_grp      = tbl_points[t] / fac;
	last_stage = (s == tbl_stages[t] - 1);
	for (int g = 0; g < n_grp; g++)
	begin
		@(negedge clk);
		// first group waits, later ones must follow on consecutive cycles
		if (g == 0)
			while (!out_valid)
				@(negedge clk);
		else
			check_flag("out_valid", 1'b1, out_valid);
		b = g / stride;
		j = g % stride;
		check_factor("out_factor", 3'(fac), out_factor);
		check_factor("out_stage", 3'(s), out_stage);
		check_idx("out_twdl_demontr", W_IDX'(span), out_twdl_demontr);
		for (int k = 0; k < N_LANES; k++)
		begin
			exp_re = '0;
			exp_im = '0;
			exp_tw = '0;
			if (k < fac)
			begin
				pt     = b * span + j + k * stride;
				exp_re = model_re[pt];
				exp_im = model_im[pt];
				exp_tw = W_IDX'(k * j);
			end
			check_sample($sformatf("out_real[%0d]", k), exp_re, out_real[k]);
			check_sample($sformatf("out_imag[%0d]", k), exp_im, out_imag[k]);
			check_idx($sformatf("out_twdl_numrtr[%0d]", k), exp_tw, out_twdl_numrtr[k]);
		end
		check_flag("stage_end", g == n_grp - 1, stage_end);
		check_flag("done", last_stage && g == n_grp - 1, done);
	end
endtask

initial
begin
	clk        = 1'b0;
	rst_n      = 1'b0;
	start      = 1'b0;
	num_stages = '0;
	factor     = '0;
	in_valid   = 1'b0;
	in_real    = '0;
	in_imag    = '0;
	void'($urandom(32'hcc83263b));

	cycle_limit = 200;
	for (int t = 0; t < N_TESTS; t++)
		cycle_limit += tbl_points[t] * 3
			+ tbl_stages[t] * (tbl_points[t] + WAIT_CYCLES + 8);

	repeat (10) @(posedge clk);
	#1;
	rst_n = 1'b1;
	@(negedge clk);
	check_flag("out_valid", 1'b0, out_valid);
	check_flag("done", 1'b0, done);
	check_flag("stage_end", 1'b0, stage_end);
	if (i_dut.rden !== '0)
		report_error("bank read enables are active after reset");
	if (i_dut.state !== IDLE)
		report_error("sequencer is not idle after reset");

	for (int t = 0; t < N_TESTS; t++)
	begin
		start_transform(t);
		load_samples(tbl_points[t], tbl_gap[t]);
		for (int s = 0; s < tbl_stages[t]; s++)
			collect_stage(t, s);
		// nothing more once the transform is done
		repeat (4)
		begin
			@(negedge clk);
			check_flag("out_valid", 1'b0, out_valid);
		end
	end

	$display("Simulation completed successfully");
	$finish;
end

endmodule

//--- tb.f
verilog/mrd_pkg.sv
verilog/mrd_div7.sv
verilog/mrd_bank_ram.sv
verilog/mrd_seq_fsm.sv
verilog/mrd_cta_addr.sv
verilog/mrd_rd_sched.sv
verilog/mrd_top.sv
dv/tb_mrd_top.sv

//--- Bender.yml
package:
  name: mrd_dft_mem

sources:
  - files:
      - verilog/mrd_pkg.sv
      - verilog/mrd_div7.sv
      - verilog/mrd_bank_ram.sv
      - verilog/mrd_seq_fsm.sv
      - verilog/mrd_cta_addr.sv
      - verilog/mrd_rd_sched.sv
      - verilog/mrd_top.sv
  - target: simulation
    files:
      - dv/tb_mrd_top.sv
